// File: Makefile
VERILATOR ?= verilator
TOP       ?= io_subsystem_tb
FILELIST  ?= io_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verification/*.sv verification/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: io_subsystem.f
+incdir+verification
verilog/bus_pkg.sv
verilog/periph_pkg.sv
verilog/io_decoder.sv
verilog/leds_register.sv
verilog/uart_ports.sv
verilog/spi_ports.sv
verilog/io_subsystem.sv
verification/io_subsystem_tb.sv

// File: verification/io_tb_tasks.svh
`ifndef IO_TB_TASKS_SVH
`define IO_TB_TASKS_SVH

task automatic report_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [15:0] actual,
                           input logic [15:0] expected);
    if (actual !== expected) begin
        report_failure($sformatf("[ERROR] %s: got 0x%04h, expected 0x%04h",
                                 name, actual, expected));
    end
endtask

// One handshake. The request changes on the rising edge and ack is sampled
// on the falling edge, where it is stable.
task automatic bus_access(input logic [15:0] port, input logic wr_en,
                          input logic [15:0] wdata, input logic [1:0] bytesel,
                          output logic [15:0] rdata);
    int cycles;
    @(posedge clk);
    req <= '{access: 1'b1, addr: port[15:1], wdata: wdata, wr_en: wr_en, bytesel: bytesel};
    cycles = 0;
    @(negedge clk);
    while (!rsp.ack && cycles < bus_timeout) begin
        @(negedge clk);
        cycles++;
    end
    if (!rsp.ack) begin
        report_failure($sformatf("No ack from port 0x%04h within %0d cycles", port, bus_timeout));
    end
    check_value("ack latency", 16'(cycles), 16'd1);
    rdata = rsp.rdata;
    @(posedge clk);
    req <= '0;
    @(negedge clk);
endtask

task automatic bus_write(input logic [15:0] port, input logic [15:0] wdata,
                         input logic [1:0] bytesel);
    logic [15:0] ignored;
    bus_access(port, 1'b1, wdata, bytesel, ignored);
endtask

task automatic bus_read(input logic [15:0] port, input logic [1:0] bytesel,
                        output logic [15:0] rdata);
    bus_access(port, 1'b0, 16'h0000, bytesel, rdata);
endtask

// Reads with bytesel 2'b10 so that a pending UART byte stays valid.
task automatic poll_status(input logic [15:0] port, input logic [15:0] mask,
                           input logic [15:0] value, input string what,
                           output logic [15:0] status);
    int polls;
    polls = 0;
    bus_read(port, 2'b10, status);
    while ((status & mask) != value && polls < poll_limit) begin
        bus_read(port, 2'b10, status);
        polls++;
    end
    if ((status & mask) != value) begin
        report_failure($sformatf("Timed out after %0d reads waiting for %s", polls, what));
    end
endtask

task automatic test_reset_and_leds();
    logic [7:0]  value;
    logic [15:0] rdata;
    check_value("uart_tx", 16'(uart_tx), 16'h0001);
    check_value("spi_ncs", 16'(spi_ncs), 16'h0001);
    check_value("spi_sclk", 16'(spi_sclk), 16'h0000);
    check_value("spi_mosi", 16'(spi_mosi), 16'h0000);
    check_value("leds", 16'(leds), 16'h0000);
    value = 8'h00;
    repeat (4) begin
        value = 8'($urandom);
        bus_write(bus_pkg::leds_port, {8'($urandom), value}, 2'b01);
        check_value("leds", 16'(leds), 16'(value));
        bus_read(bus_pkg::leds_port, 2'b11, rdata);
        check_value("leds rdata", rdata, 16'(value));
    end
    // The high lane alone must not reach the LEDs.
    bus_write(bus_pkg::leds_port, {value, ~value}, 2'b10);
    check_value("leds", 16'(leds), 16'(value));
endtask

task automatic test_ack_latency();
    logic [15:0] rdata;
    bus_read(16'h0040, 2'b11, rdata);
    check_value("unmapped rdata", rdata, 16'h0000);
    bus_write(16'h0040, 16'hffff, 2'b11);
    bus_read(16'hfffc, 2'b11, rdata);
    check_value("unmapped rdata", rdata, 16'h0000);
    bus_read(16'hfff4, 2'b11, rdata);
    check_value("unmapped rdata", rdata, 16'h0000);
    repeat (4) begin
        bus_read({1'b0, 14'($urandom), 1'b0}, 2'b11, rdata);
        check_value("unmapped rdata", rdata, 16'h0000);
    end
    bus_read(bus_pkg::uart_port, 2'b10, rdata);
    check_value("uart status", rdata, 16'h0000);
    bus_read(bus_pkg::spi_ctrl_port, 2'b11, rdata);
    check_value("spi status", rdata, 16'h0000);
    bus_read(bus_pkg::spi_data_port, 2'b11, rdata);
    check_value("spi status", rdata, 16'h0000);
endtask

task automatic test_uart_loopback();
    logic [7:0]  value;
    logic [15:0] status;
    value = 8'($urandom);
    bus_write(bus_pkg::uart_port, {8'h00, value}, 2'b01);
    poll_status(bus_pkg::uart_port, rx_valid_mask, rx_valid_mask, "UART rx_valid", status);
    poll_status(bus_pkg::uart_port, tx_busy_mask, 16'h0000, "UART tx_busy to clear", status);
    bus_read(bus_pkg::uart_port, 2'b01, status);
    check_value("uart status", status, {6'b0, 1'b0, 1'b1, value});
    bus_read(bus_pkg::uart_port, 2'b01, status);
    check_value("uart status", status, {6'b0, 1'b0, 1'b0, value});
endtask

task automatic test_uart_busy_drop();
    logic [7:0]  first;
    logic [15:0] status;
    first = 8'($urandom);
    bus_write(bus_pkg::uart_port, {8'h00, first}, 2'b01);
    bus_read(bus_pkg::uart_port, 2'b10, status);
    check_value("uart tx_busy", 16'(status[9]), 16'h0001);
    bus_write(bus_pkg::uart_port, {8'h00, ~first}, 2'b01);
    poll_status(bus_pkg::uart_port, rx_valid_mask, rx_valid_mask, "UART rx_valid", status);
    bus_read(bus_pkg::uart_port, 2'b01, status);
    check_value("uart rx", status & 16'h01ff, {7'h00, 1'b1, first});
    repeat (2 * uart_char_cycles) @(posedge clk);
    @(negedge clk);
    bus_read(bus_pkg::uart_port, 2'b01, status);
    check_value("uart status", status, {8'h00, first});
endtask

task automatic spi_loopback_run(input logic [7:0] divider);
    bus_pkg::spi_wdata_u word;
    logic [7:0]          value;
    logic [15:0]         status;
    word = '0;
    word.ctrl.ncs_active = 1'b1;
    word.ctrl.divider    = divider;
    bus_write(bus_pkg::spi_ctrl_port, word, 2'b11);
    check_value("spi_ncs", 16'(spi_ncs), 16'h0000);
    repeat (3) begin
        value = 8'($urandom);
        word = '0;
        word.xfer.tx_byte = value;
        bus_write(bus_pkg::spi_data_port, word, 2'b11);
        poll_status(bus_pkg::spi_data_port, spi_busy_mask, 16'h0000, "SPI busy to clear",
                    status);
        check_value("spi status", status, {6'b0, 1'b1, 1'b0, value});
    end
endtask

task automatic test_spi_loopback();
    spi_loopback_run(8'd0);
    spi_loopback_run(8'd3);
    bus_write(bus_pkg::spi_ctrl_port, 16'h0003, 2'b11);
    check_value("spi_ncs", 16'(spi_ncs), 16'h0001);
endtask

task automatic test_spi_busy_drop();
    logic [7:0]  first;
    logic [15:0] status;
    first = 8'($urandom);
    bus_write(bus_pkg::spi_data_port, {8'h00, first}, 2'b11);
    bus_read(bus_pkg::spi_data_port, 2'b11, status);
    check_value("spi busy", 16'(status[8]), 16'h0001);
    bus_write(bus_pkg::spi_data_port, {8'h00, ~first}, 2'b11);
    poll_status(bus_pkg::spi_data_port, spi_busy_mask, 16'h0000, "SPI busy to clear", status);
    check_value("spi status", status, {8'h00, first});
endtask

`endif

// File: verification/io_subsystem_tb.sv
module io_subsystem_tb;

    localparam int bus_timeout      = 8;
    localparam int poll_limit       = 200;
    localparam int uart_char_cycles = 10 * periph_pkg::uart_clks_per_bit;

    // Status bit positions for the UART and SPI ports.
    localparam logic [15:0] rx_valid_mask = 16'h0100;
    localparam logic [15:0] tx_busy_mask  = 16'h0200;
    localparam logic [15:0] spi_busy_mask = 16'h0100;

    logic              clk = 1'b0;
    logic              rst;
    bus_pkg::bus_req_t req;
    bus_pkg::bus_rsp_t rsp;
    logic [7:0]        leds;
    logic              uart_rx;
    logic              uart_tx;
    logic              spi_miso;
    logic              spi_sclk;
    logic              spi_mosi;
    logic              spi_ncs;

    io_subsystem i_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rsp      (rsp),
        .leds     (leds),
        .uart_rx  (uart_rx),
        .uart_tx  (uart_tx),
        .spi_miso (spi_miso),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_ncs  (spi_ncs)
    );

    // Both serial links are looped back onto themselves.
    assign uart_rx  = uart_tx;
    assign spi_miso = spi_mosi;

    always #20 clk = ~clk;

    `include "io_tb_tasks.svh"

    initial begin
        rst = 1'b1;
        req = '0;
        void'($urandom(32'h95c6_4198));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        test_reset_and_leds();
        test_ack_latency();
        test_uart_loopback();
        test_uart_busy_drop();
        test_spi_loopback();
        test_spi_busy_drop();

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

    // One word access from the bus master. The address holds port bits 15 to 1.
    typedef struct packed {
        logic        access;
        logic [15:1] addr;
        logic [15:0] wdata;
        logic        wr_en;
        logic [1:0]  bytesel;
    } bus_req_t;

    // Responses from all peripherals are ORed, so rdata stays zero without ack.
    typedef struct packed {
        logic [15:0] rdata;
        logic        ack;
    } bus_rsp_t;

    localparam logic [15:0] leds_port     = 16'hfffe;
    localparam logic [15:0] uart_port     = 16'hfffa;
    localparam logic [15:0] spi_ctrl_port = 16'hfff0;
    localparam logic [15:0] spi_data_port = 16'hfff2;

    typedef struct packed {
        logic [6:0] unused;
        logic       ncs_active;
        logic [7:0] divider;
    } spi_ctrl_word_t;

    typedef struct packed {
        logic [7:0] unused;
        logic [7:0] tx_byte;
    } spi_xfer_word_t;

    // The SPI write word is read as control or as transfer data by port.
    typedef union packed {
        spi_ctrl_word_t ctrl;
        spi_xfer_word_t xfer;
    } spi_wdata_u;

endpackage

// File: verilog/io_decoder.sv
module io_decoder (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    output logic              leds_sel,
    output logic              uart_sel,
    output logic              spi_sel,
    input  bus_pkg::bus_rsp_t leds_rsp,
    input  bus_pkg::bus_rsp_t uart_rsp,
    input  bus_pkg::bus_rsp_t spi_rsp,
    output bus_pkg::bus_rsp_t rsp
);

    logic [15:0] port;
    logic        default_sel;
    logic        default_ack;

    assign port = {req.addr, 1'b0};

    // The SPI pair shares one select; bit 1 picks the port inside spi_ports.
    always_comb begin
        leds_sel    = 1'b0;
        uart_sel    = 1'b0;
        spi_sel     = 1'b0;
        default_sel = 1'b0;
        if (req.access) begin
            if (port == bus_pkg::leds_port) begin
                leds_sel = 1'b1;
            end else if (port == bus_pkg::uart_port) begin
                uart_sel = 1'b1;
            end else if (port[15:2] == bus_pkg::spi_ctrl_port[15:2]) begin
                spi_sel = 1'b1;
            end else begin
                default_sel = 1'b1;
            end
        end
    end

    // Unmapped ports are acknowledged with zero data.
    always_ff @(posedge clk) begin
        if (rst) begin
            default_ack <= 1'b0;
        end else begin
            default_ack <= default_sel && !default_ack;
        end
    end

    assign rsp.rdata = leds_rsp.rdata | uart_rsp.rdata | spi_rsp.rdata;
    assign rsp.ack   = leds_rsp.ack | uart_rsp.ack | spi_rsp.ack | default_ack;

    // The merge relies on a single responder answering at a time.
    a_one_ack: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({leds_rsp.ack, uart_rsp.ack, spi_rsp.ack, default_ack})
    );

endmodule

// File: verilog/io_subsystem.sv
module io_subsystem (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    output logic [7:0]        leds,
    input  logic              uart_rx,
    output logic              uart_tx,
    input  logic              spi_miso,
    output logic              spi_sclk,
    output logic              spi_mosi,
    output logic              spi_ncs
);

    logic              leds_sel;
    logic              uart_sel;
    logic              spi_sel;
    bus_pkg::bus_rsp_t leds_rsp;
    bus_pkg::bus_rsp_t uart_rsp;
    bus_pkg::bus_rsp_t spi_rsp;

    io_decoder i_decoder (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .leds_sel (leds_sel),
        .uart_sel (uart_sel),
        .spi_sel  (spi_sel),
        .leds_rsp (leds_rsp),
        .uart_rsp (uart_rsp),
        .spi_rsp  (spi_rsp),
        .rsp      (rsp)
    );

    leds_register i_leds (
        .clk  (clk),
        .rst  (rst),
        .sel  (leds_sel),
        .req  (req),
        .rsp  (leds_rsp),
        .leds (leds)
    );

    uart_ports i_uart (
        .clk (clk),
        .rst (rst),
        .sel (uart_sel),
        .req (req),
        .rsp (uart_rsp),
        .rx  (uart_rx),
        .tx  (uart_tx)
    );

    spi_ports i_spi (
        .clk  (clk),
        .rst  (rst),
        .sel  (spi_sel),
        .req  (req),
        .rsp  (spi_rsp),
        .miso (spi_miso),
        .sclk (spi_sclk),
        .mosi (spi_mosi),
        .ncs  (spi_ncs)
    );

endmodule

// File: verilog/leds_register.sv
module leds_register (
    input  logic              clk,
    input  logic              rst,
    input  logic              sel,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    output logic [7:0]        leds
);

    logic take;

    // An access is taken once, in the cycle before its ack.
    assign take = sel && !rsp.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp  <= '0;
            leds <= 8'h00;
        end else begin
            rsp.ack   <= take;
            rsp.rdata <= '0;
            if (take) begin
                if (req.wr_en) begin
                    // Only the low byte drives LEDs.
                    if (req.bytesel[0]) begin
                        leds <= req.wdata[7:0];
                    end
                end else begin
                    rsp.rdata <= {8'h00, leds};
                end
            end
        end
    end

endmodule

// File: verilog/periph_pkg.sv
package periph_pkg;

    // A UART character is a start bit, eight data bits and a stop bit.
    localparam int uart_clks_per_bit  = 16;
    localparam int uart_bits_per_char = 10;
    localparam int uart_cnt_w         = $clog2(uart_clks_per_bit);

    localparam logic [uart_cnt_w-1:0] uart_bit_last  = uart_cnt_w'(uart_clks_per_bit - 1);
    localparam logic [uart_cnt_w-1:0] uart_half_last = uart_cnt_w'(uart_clks_per_bit / 2 - 1);
    localparam logic [3:0]            uart_stop_bit  = 4'(uart_bits_per_char - 1);

    typedef struct packed {
        logic [5:0] reserved;
        logic       tx_busy;
        logic       rx_valid;
        logic [7:0] rx_byte;
    } uart_status_t;

    // Both SPI ports read back this word.
    typedef struct packed {
        logic [5:0] reserved;
        logic       ncs_active;
        logic       busy;
        logic [7:0] rx_byte;
    } spi_status_t;

endpackage

// File: verilog/spi_ports.sv
module spi_ports (
    input  logic              clk,
    input  logic              rst,
    input  logic              sel,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    input  logic              miso,
    output logic              sclk,
    output logic              mosi,
    output logic              ncs
);

    logic                    take;
    logic                    data_port;
    bus_pkg::spi_wdata_u     wd;
    logic [7:0]              divider;
    logic                    ncs_active;
    logic                    busy;
    logic [7:0]              half_cnt;
    logic [3:0]              edge_cnt;
    logic [6:0]              tx_shift;
    logic [7:0]              rx_shift;
    logic [7:0]              rx_byte;
    periph_pkg::spi_status_t status;

    assign take      = sel && !rsp.ack;
    assign data_port = req.addr[1] == bus_pkg::spi_data_port[1];
    assign wd        = req.wdata;
    assign ncs       = !ncs_active;

    assign status.reserved   = '0;
    assign status.ncs_active = ncs_active;
    assign status.busy       = busy;
    assign status.rx_byte    = rx_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp        <= '0;
            divider    <= 8'h00;
            ncs_active <= 1'b0;
            busy       <= 1'b0;
            sclk       <= 1'b0;
            mosi       <= 1'b0;
            rx_byte    <= 8'h00;
        end else begin
            rsp.ack   <= take;
            rsp.rdata <= '0;
            if (take && !req.wr_en) begin
                rsp.rdata <= status;
            end
            if (take && req.wr_en && !data_port) begin
                divider    <= wd.ctrl.divider;
                ncs_active <= wd.ctrl.ncs_active;
            end

            // Sixteen half periods per byte. Rising edges sample miso and
            // falling edges move mosi to the next bit, MSB first.
            if (busy) begin
                if (half_cnt == divider) begin
                    half_cnt <= 8'h00;
                    sclk     <= !sclk;
                    edge_cnt <= edge_cnt + 4'd1;
                    if (!sclk) begin
                        rx_shift <= {rx_shift[6:0], miso};
                    end else if (edge_cnt == 4'd15) begin
                        busy    <= 1'b0;
                        rx_byte <= rx_shift;
                    end else begin
                        mosi     <= tx_shift[6];
                        tx_shift <= {tx_shift[5:0], 1'b0};
                    end
                end else begin
                    half_cnt <= half_cnt + 8'd1;
                end
            end else if (take && req.wr_en && data_port) begin
                busy     <= 1'b1;
                half_cnt <= 8'h00;
                edge_cnt <= 4'd0;
                mosi     <= wd.xfer.tx_byte[7];
                tx_shift <= wd.xfer.tx_byte[6:0];
            end
        end
    end

    a_sclk_idle_low: assert property (
        @(posedge clk) disable iff (rst)
        !busy |-> !sclk
    );

endmodule

// File: verilog/uart_ports.sv
module uart_ports (
    input  logic              clk,
    input  logic              rst,
    input  logic              sel,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    input  logic              rx,
    output logic              tx
);

    logic                              take;
    logic                              tx_start;
    logic                              rx_clear;
    logic                              tx_busy;
    logic [8:0]                        tx_shift;
    logic [3:0]                        tx_bit;
    logic [periph_pkg::uart_cnt_w-1:0] tx_clk;
    logic [1:0]                        rx_sync;
    logic                              rx_active;
    logic                              rx_tick;
    logic [3:0]                        rx_bit;
    logic [periph_pkg::uart_cnt_w-1:0] rx_clk;
    logic [7:0]                        rx_shift;
    logic [7:0]                        rx_byte;
    logic                              rx_valid;
    periph_pkg::uart_status_t          status;

    assign take     = sel && !rsp.ack;
    assign tx_start = take && req.wr_en && req.bytesel[0] && !tx_busy;
    assign rx_clear = take && !req.wr_en && req.bytesel[0];

    assign status.reserved = '0;
    assign status.tx_busy  = tx_busy;
    assign status.rx_valid = rx_valid;
    assign status.rx_byte  = rx_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp <= '0;
        end else begin
            rsp.ack   <= take;
            rsp.rdata <= '0;
            if (take && !req.wr_en) begin
                rsp.rdata <= status;
            end
        end
    end

    // Transmitter. The shift register holds the data bits and the stop bit,
    // the start bit is driven directly when the character is loaded.
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy <= 1'b0;
            tx      <= 1'b1;
        end else if (tx_busy) begin
            if (tx_clk == periph_pkg::uart_bit_last) begin
                tx_clk <= '0;
                if (tx_bit == periph_pkg::uart_stop_bit) begin
                    tx_busy <= 1'b0;
                    tx      <= 1'b1;
                end else begin
                    tx       <= tx_shift[0];
                    tx_shift <= {1'b1, tx_shift[8:1]};
                    tx_bit   <= tx_bit + 4'd1;
                end
            end else begin
                tx_clk <= tx_clk + 1'b1;
            end
        end else if (tx_start) begin
            tx_busy  <= 1'b1;
            tx       <= 1'b0;
            tx_shift <= {1'b1, req.wdata[7:0]};
            tx_bit   <= 4'd0;
            tx_clk   <= '0;
        end
    end

    // The start bit is checked half a bit in, then every bit is sampled mid-bit.
    assign rx_tick = rx_clk == ((rx_bit == 4'd0) ? periph_pkg::uart_half_last
                                                 : periph_pkg::uart_bit_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync   <= 2'b11;
            rx_active <= 1'b0;
            rx_valid  <= 1'b0;
            rx_byte   <= 8'h00;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            if (rx_clear) begin
                rx_valid <= 1'b0;
            end
            if (!rx_active) begin
                if (!rx_sync[1]) begin
                    rx_active <= 1'b1;
                    rx_bit    <= 4'd0;
                    rx_clk    <= '0;
                end
            end else if (rx_tick) begin
                rx_clk <= '0;
                if (rx_bit == 4'd0) begin
                    // A glitch that is gone by mid start bit is no character.
                    if (rx_sync[1]) begin
                        rx_active <= 1'b0;
                    end else begin
                        rx_bit <= 4'd1;
                    end
                end else if (rx_bit == periph_pkg::uart_stop_bit) begin
                    rx_active <= 1'b0;
                    if (rx_sync[1]) begin
                        rx_byte  <= rx_shift;
                        rx_valid <= 1'b1;
                    end
                end else begin
                    rx_shift <= {rx_sync[1], rx_shift[7:1]};
                    rx_bit   <= rx_bit + 4'd1;
                end
            end else begin
                rx_clk <= rx_clk + 1'b1;
            end
        end
    end

    a_tx_idle_high: assert property (
        @(posedge clk) disable iff (rst)
        !tx_busy |-> tx
    );

endmodule
